// File: source/overlay_params.svh
`ifndef OVERLAY_PARAMS_SVH
`define OVERLAY_PARAMS_SVH

// Width of one real or imaginary half
`define DATA_WIDTH 16

// Elements in the row, also the batch length in words
`define PE_NUM 4

// Opcode in the upper two bits, shift amount below
`define INST_WIDTH 5

`endif

// File: source/overlay_pkg.sv
`default_nettype none

`include "overlay_params.svh"

package overlay_pkg;

    typedef enum logic [1:0] {
        OP_PASS  = 2'd0,
        OP_ADD   = 2'd1,
        OP_CONJ  = 2'd2,
        OP_SCALE = 2'd3
    } opcode_e;

    // Real half in the upper bits
    typedef struct packed {
        logic signed [`DATA_WIDTH-1:0] re;
        logic signed [`DATA_WIDTH-1:0] im;
    } cplx_t;

    typedef struct packed {
        opcode_e                 opcode;
        logic [`INST_WIDTH-3:0]  shamt;
    } inst_t;

endpackage

`default_nettype wire

// File: source/sipo_in_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "overlay_params.svh"

module sipo_in_buffer (
    input  wire logic                                       clk,
    input  wire logic                                       rst_n,
    input  wire logic                                       ce,
    input  wire logic                                       din_v,
    input  wire overlay_pkg::cplx_t                         din,
    output logic                                            batch_v,
    output logic [`PE_NUM*$bits(overlay_pkg::cplx_t)-1:0]  batch_words
);

    localparam int WORD_W = $bits(overlay_pkg::cplx_t);
    localparam int CNT_W  = $clog2(`PE_NUM);

    logic [CNT_W-1:0] word_cnt;
    logic             last_word;

    assign last_word = (word_cnt == CNT_W'(`PE_NUM - 1));

    //////////////////////////////////////////////////
    // Word counter and batch strobe
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_cnt <= '0;
            batch_v  <= 1'b0;
        end else if (ce) begin
            batch_v <= din_v && last_word;
            if (din_v) begin
                word_cnt <= last_word ? '0 : word_cnt + 1'b1;
            end
        end
    end

    // New word enters the top slice, first word of a batch lands in slice 0
    always_ff @(posedge clk) begin
        if (ce && din_v) begin
            batch_words <= {din, batch_words[`PE_NUM*WORD_W-1:WORD_W]};
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    // A batch needs at least two samples, so strobes never touch
    assert property (@(posedge clk) disable iff (!rst_n)
        (ce && batch_v) |=> !batch_v)
        else $error("batch_v high on consecutive enabled cycles");

endmodule

`default_nettype wire

// File: source/pe.sv
`timescale 1ns/1ps
`default_nettype none

module pe (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                ce,
    input  wire logic                din_pe_v,
    input  wire overlay_pkg::cplx_t  din_pe,
    input  wire overlay_pkg::cplx_t  tx_in,
    input  wire logic                inst_v,
    input  wire overlay_pkg::inst_t  inst,
    output overlay_pkg::cplx_t       tx_out,
    output logic                     res_v,
    output overlay_pkg::cplx_t       res
);

    overlay_pkg::inst_t inst_q;
    overlay_pkg::cplx_t calc;

    //////////////////////////////////////////////////
    // Instruction register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inst_q.opcode <= overlay_pkg::OP_PASS;
            inst_q.shamt  <= '0;
        end else if (ce && inst_v) begin
            inst_q <= inst;
        end
    end

    //////////////////////////////////////////////////
    // Opcode datapath
    //////////////////////////////////////////////////
    always_comb begin
        calc = din_pe;
        unique case (inst_q.opcode)
            overlay_pkg::OP_PASS: begin
                calc = din_pe;
            end
            overlay_pkg::OP_ADD: begin
                // Each half wraps on its own
                calc.re = din_pe.re + tx_in.re;
                calc.im = din_pe.im + tx_in.im;
            end
            overlay_pkg::OP_CONJ: begin
                calc.re = din_pe.re;
                calc.im = -din_pe.im;
            end
            overlay_pkg::OP_SCALE: begin
                calc.re = $signed(din_pe.re) >>> inst_q.shamt;
                calc.im = $signed(din_pe.im) >>> inst_q.shamt;
            end
        endcase
    end

    // Chain to the right neighbor is the unregistered result
    assign tx_out = calc;

    //////////////////////////////////////////////////
    // Result register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_v <= 1'b0;
        end else if (ce) begin
            res_v <= din_pe_v;
        end
    end

    always_ff @(posedge clk) begin
        if (ce && din_pe_v) begin
            res <= calc;
        end
    end

    // Opcode must stay known once out of reset
    assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(inst_q.opcode))
        else $error("held opcode is unknown");

endmodule

`default_nettype wire

// File: source/piso_out_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "overlay_params.svh"

module piso_out_buffer (
    input  wire logic                                       clk,
    input  wire logic                                       rst_n,
    input  wire logic                                       ce,
    input  wire logic                                       load_v,
    input  wire logic [`PE_NUM*$bits(overlay_pkg::cplx_t)-1:0] par_words,
    output logic                                            dout_v,
    output overlay_pkg::cplx_t                              dout
);

    localparam int WORD_W = $bits(overlay_pkg::cplx_t);
    localparam int REM_W  = $clog2(`PE_NUM + 1);

    logic [`PE_NUM*WORD_W-1:0] shreg;
    logic [REM_W-1:0]          remain;

    //////////////////////////////////////////////////
    // Remaining word count
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            remain <= '0;
        end else if (ce) begin
            if (load_v) begin
                remain <= REM_W'(`PE_NUM);
            end else if (remain != '0) begin
                remain <= remain - 1'b1;
            end
        end
    end

    // Shift toward slice 0 once per enabled cycle while words remain
    always_ff @(posedge clk) begin
        if (ce) begin
            if (load_v) begin
                shreg <= par_words;
            end else if (remain != '0) begin
                shreg <= shreg >> WORD_W;
            end
        end
    end

    assign dout_v = (remain != '0);
    assign dout   = shreg[WORD_W-1:0];

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    // Only the last word may still be on the output when the next load lands
    assert property (@(posedge clk) disable iff (!rst_n)
        (ce && load_v) |-> (remain <= REM_W'(1)))
        else $error("output buffer loaded while words remain");

endmodule

`default_nettype wire

// File: source/overlay.sv
`timescale 1ns/1ps
`default_nettype none

`include "overlay_params.svh"

module overlay (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                ce,
    input  wire logic                din_v,
    input  wire overlay_pkg::cplx_t  din,
    input  wire logic                inst_v,
    input  wire overlay_pkg::inst_t  inst,
    output logic                     dout_v,
    output overlay_pkg::cplx_t       dout
);

    localparam int WORD_W = $bits(overlay_pkg::cplx_t);

    logic                      batch_v;
    logic [`PE_NUM*WORD_W-1:0] batch_words;
    logic [`PE_NUM*WORD_W-1:0] res_words;
    logic                      res_v;
    overlay_pkg::cplx_t        tx [`PE_NUM];

    //////////////////////////////////////////////////
    // Input side
    //////////////////////////////////////////////////
    sipo_in_buffer in_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .ce          (ce),
        .din_v       (din_v),
        .din         (din),
        .batch_v     (batch_v),
        .batch_words (batch_words)
    );

    //////////////////////////////////////////////////
    // Element row
    //////////////////////////////////////////////////
    genvar i;
    generate
        for (i = 0; i < `PE_NUM; i = i + 1) begin : array
            if (i == 0) begin : g_head
                // Head of the chain sees zero, its res_v paces the output
                pe u_pe (
                    .clk      (clk),
                    .rst_n    (rst_n),
                    .ce       (ce),
                    .din_pe_v (batch_v),
                    .din_pe   (batch_words[i*WORD_W +: WORD_W]),
                    .tx_in    ('0),
                    .inst_v   (inst_v),
                    .inst     (inst),
                    .tx_out   (tx[i]),
                    .res_v    (res_v),
                    .res      (res_words[i*WORD_W +: WORD_W])
                );
            end else begin : g_link
                pe u_pe (
                    .clk      (clk),
                    .rst_n    (rst_n),
                    .ce       (ce),
                    .din_pe_v (batch_v),
                    .din_pe   (batch_words[i*WORD_W +: WORD_W]),
                    .tx_in    (tx[i-1]),
                    .inst_v   (inst_v),
                    .inst     (inst),
                    .tx_out   (tx[i]),
                    .res_v    (),
                    .res      (res_words[i*WORD_W +: WORD_W])
                );
            end
        end
    endgenerate

    //////////////////////////////////////////////////
    // Output side
    //////////////////////////////////////////////////
    piso_out_buffer out_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .ce        (ce),
        .load_v    (res_v),
        .par_words (res_words),
        .dout_v    (dout_v),
        .dout      (dout)
    );

endmodule

`default_nettype wire

// File: dv/overlay_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "overlay_params.svh"

module overlay_tb;

    localparam int WORD_W  = $bits(overlay_pkg::cplx_t);
    localparam int N_TAB   = 8;
    localparam int N_RAND  = 8;
    localparam int N_BATCH = N_TAB + N_RAND;
    localparam int LIMIT   = N_BATCH * (`PE_NUM + 4) * 3 + 10;

    typedef overlay_pkg::cplx_t batch_t [`PE_NUM];

    logic               clk;
    logic               rst_n;
    logic               ce;
    logic               din_v;
    overlay_pkg::cplx_t din;
    logic               inst_v;
    overlay_pkg::inst_t inst;
    logic               dout_v;
    overlay_pkg::cplx_t dout;

    // Word 0 sits in the upper bits of each table row
    overlay_pkg::inst_t        tab_inst [N_TAB];
    logic [`PE_NUM*WORD_W-1:0] tab_in   [N_TAB];
    logic [`PE_NUM*WORD_W-1:0] tab_exp  [N_TAB];

    overlay_pkg::cplx_t exp_w    [N_BATCH][`PE_NUM];
    overlay_pkg::inst_t bat_inst [N_BATCH];
    int                 got_cnt  [N_BATCH];
    int                 mism     [N_BATCH];
    int                 n_err;
    int                 n_words;
    int                 cycles;
    integer             seed;
    int                 out_b;
    logic               in_burst;

    overlay i_overlay (
        .clk    (clk),
        .rst_n  (rst_n),
        .ce     (ce),
        .din_v  (din_v),
        .din    (din),
        .inst_v (inst_v),
        .inst   (inst),
        .dout_v (dout_v),
        .dout   (dout)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Reference rules and table
    //////////////////////////////////////////////////
    function automatic overlay_pkg::cplx_t model_word(input overlay_pkg::inst_t x,
                                                      input batch_t b, input int k);
        overlay_pkg::cplx_t r;
        logic [`DATA_WIDTH-1:0] sr;
        logic [`DATA_WIDTH-1:0] si;
        r  = b[k];
        sr = '0;
        si = '0;
        case (x.opcode)
            overlay_pkg::OP_ADD: begin
                // Running sum over elements 0..k, each half wraps
                for (int j = 0; j <= k; j++) begin
                    sr = sr + b[j].re;
                    si = si + b[j].im;
                end
                r.re = sr;
                r.im = si;
            end
            overlay_pkg::OP_CONJ:  r.im = -b[k].im;
            overlay_pkg::OP_SCALE: begin
                r.re = b[k].re >>> x.shamt;
                r.im = b[k].im >>> x.shamt;
            end
            default: r = b[k];
        endcase
        return r;
    endfunction

    task automatic fill_table();
        tab_inst[0] = '{opcode: overlay_pkg::OP_PASS, shamt: 3'd0};
        tab_in[0]   = {32'h0001_0002, 32'h0003_fffc, 32'h7fff_8000, 32'hffff_0005};
        tab_exp[0]  = {32'h0001_0002, 32'h0003_fffc, 32'h7fff_8000, 32'hffff_0005};
        tab_inst[1] = '{opcode: overlay_pkg::OP_ADD, shamt: 3'd0};
        tab_in[1]   = {32'h0001_000a, 32'h0002_0014, 32'h0003_001e, 32'h0004_0028};
        tab_exp[1]  = {32'h0001_000a, 32'h0003_001e, 32'h0006_003c, 32'h000a_0064};
        // Overflow in both halves
        tab_inst[2] = '{opcode: overlay_pkg::OP_ADD, shamt: 3'd0};
        tab_in[2]   = {32'h7fff_8000, 32'h0001_ffff, 32'h7fff_7fff, 32'h0002_8001};
        tab_exp[2]  = {32'h7fff_8000, 32'h8000_7fff, 32'hffff_fffe, 32'h0001_7fff};
        tab_inst[3] = '{opcode: overlay_pkg::OP_CONJ, shamt: 3'd0};
        tab_in[3]   = {32'h0005_0003, 32'hfffe_fff9, 32'h0000_8000, 32'h0064_0000};
        tab_exp[3]  = {32'h0005_fffd, 32'hfffe_0007, 32'h0000_8000, 32'h0064_0000};
        tab_inst[4] = '{opcode: overlay_pkg::OP_SCALE, shamt: 3'd0};
        tab_in[4]   = {32'h1234_fff8, 32'h8000_7fff, 32'h0001_ffff, 32'h00ff_ff00};
        tab_exp[4]  = {32'h1234_fff8, 32'h8000_7fff, 32'h0001_ffff, 32'h00ff_ff00};
        tab_inst[5] = '{opcode: overlay_pkg::OP_SCALE, shamt: 3'd1};
        tab_in[5]   = {32'h0008_fff8, 32'h0007_fff9, 32'hffff_0001, 32'h8000_7fff};
        tab_exp[5]  = {32'h0004_fffc, 32'h0003_fffc, 32'hffff_0000, 32'hc000_3fff};
        tab_inst[6] = '{opcode: overlay_pkg::OP_SCALE, shamt: 3'd7};
        tab_in[6]   = {32'h0100_ff00, 32'h7fff_8000, 32'h007f_ffff, 32'hff7f_0080};
        tab_exp[6]  = {32'h0002_fffe, 32'h00ff_ff00, 32'h0000_ffff, 32'hfffe_0001};
        // shamt is ignored by pass
        tab_inst[7] = '{opcode: overlay_pkg::OP_PASS, shamt: 3'd5};
        tab_in[7]   = {32'hdead_beef, 32'h0102_0304, 32'h8000_8000, 32'h0000_0000};
        tab_exp[7]  = {32'hdead_beef, 32'h0102_0304, 32'h8000_8000, 32'h0000_0000};
    endtask

    //////////////////////////////////////////////////
    // Drivers
    //////////////////////////////////////////////////
    task automatic send_idle();
        @(posedge clk);
        din_v  <= 1'b0;
        inst_v <= 1'b0;
        ce     <= 1'b1;
    endtask

    task automatic send_inst(input overlay_pkg::inst_t x);
        @(posedge clk);
        din_v  <= 1'b0;
        inst_v <= 1'b1;
        inst   <= x;
        ce     <= 1'b1;
    endtask

    // Word held with ce low for stall cycles, then taken once
    task automatic send_word(input overlay_pkg::cplx_t w, input int stall);
        @(posedge clk);
        din_v  <= 1'b1;
        din    <= w;
        inst_v <= 1'b0;
        ce     <= (stall == 0);
        if (stall > 0) begin
            repeat (stall) @(posedge clk);
            ce <= 1'b1;
        end
    endtask

    task automatic run_batch(input int b, input overlay_pkg::inst_t x, input batch_t w,
                             input batch_t ex, input bit jitter);
        int stall;
        bat_inst[b] = x;
        for (int k = 0; k < `PE_NUM; k++) begin
            exp_w[b][k] = ex[k];
        end
        send_inst(x);
        for (int k = 0; k < `PE_NUM; k++) begin
            stall = 0;
            if (jitter) begin
                if (($random(seed) & 3) == 0) send_idle();
                if ((b == N_TAB && k % 2 == 1) || ($random(seed) & 7) == 0) stall = 3;
            end
            send_word(w[k], stall);
        end
    endtask

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    task automatic check_word(input int b, input int k, input overlay_pkg::cplx_t got,
                              input overlay_pkg::cplx_t exp);
        if (got !== exp) begin
            $display("[ERROR] batch %0d word %0d dout: got %h expected %h", b, k, got, exp);
            n_err++;
            mism[b]++;
        end
    endtask

    task automatic check_count(input int b, input int got);
        if (got < `PE_NUM) begin
            $display("batch %0d produced too few words: %0d of %0d", b, got, `PE_NUM);
            n_err++;
        end else if (got > `PE_NUM) begin
            $display("batch %0d produced too many words: %0d of %0d", b, got, `PE_NUM);
            n_err++;
        end
    endtask

    // One run of dout_v over enabled edges is one batch
    always @(posedge clk) begin
        if (rst_n && ce) begin
            if (dout_v) begin
                if (!in_burst) begin
                    in_burst = 1'b1;
                    if (out_b >= N_BATCH) begin
                        $display("output word %h arrived with no batch pending", dout);
                        n_err++;
                    end
                end
                if (out_b < N_BATCH) begin
                    if (got_cnt[out_b] < `PE_NUM) begin
                        check_word(out_b, got_cnt[out_b], dout,
                                   exp_w[out_b][got_cnt[out_b]]);
                        n_words++;
                    end
                    got_cnt[out_b]++;
                end
            end else if (in_burst) begin
                in_burst = 1'b0;
                if (out_b < N_BATCH) begin
                    $display("batch %0d %s shamt %0d: %0d words, %0d mismatches, %s",
                             out_b, bat_inst[out_b].opcode.name(), bat_inst[out_b].shamt,
                             got_cnt[out_b], mism[out_b],
                             (mism[out_b] == 0 && got_cnt[out_b] == `PE_NUM) ?
                             "pass" : "fail");
                end
                out_b++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles with %0d of %0d batches received",
                     cycles, out_b, N_BATCH);
            $display("Test FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        batch_t w;
        batch_t ex;
        overlay_pkg::inst_t x;
        logic [31:0] rnd;
        seed   = 47962;
        n_err  = 0;
        n_words = 0;
        cycles = 0;
        out_b  = 0;
        in_burst = 1'b0;
        rst_n  = 1'b0;
        ce     = 1'b1;
        din_v  = 1'b0;
        din    = '0;
        inst_v = 1'b0;
        inst   = '0;
        for (int b = 0; b < N_BATCH; b++) begin
            got_cnt[b] = 0;
            mism[b]    = 0;
        end
        fill_table();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        send_idle();

        // Each new instruction lands right after the previous batch's last word
        for (int e = 0; e < N_TAB; e++) begin
            for (int k = 0; k < `PE_NUM; k++) begin
                w[k]  = tab_in[e][(`PE_NUM-1-k)*WORD_W +: WORD_W];
                ex[k] = tab_exp[e][(`PE_NUM-1-k)*WORD_W +: WORD_W];
            end
            run_batch(e, tab_inst[e], w, ex, 1'b0);
        end

        for (int r = 0; r < N_RAND; r++) begin
            rnd      = $random(seed);
            x.opcode = overlay_pkg::opcode_e'(rnd[1:0]);
            x.shamt  = rnd[4:2];
            for (int k = 0; k < `PE_NUM; k++) begin
                w[k] = $random(seed);
            end
            for (int k = 0; k < `PE_NUM; k++) begin
                ex[k] = model_word(x, w, k);
            end
            run_batch(N_TAB + r, x, w, ex, 1'b1);
        end

        send_idle();
        while (out_b < N_BATCH) @(posedge clk);
        // Room for any stray trailing words
        repeat (`PE_NUM + 4) @(posedge clk);
        for (int b = 0; b < N_BATCH; b++) begin
            check_count(b, got_cnt[b]);
        end
        $display("%0d batches, %0d words checked, %0d errors", N_BATCH, n_words, n_err);
        if (n_err == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+source
source/overlay_pkg.sv
source/sipo_in_buffer.sv
source/pe.sv
source/piso_out_buffer.sv
source/overlay.sv
dv/overlay_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert --timescale 1ns/1ps
TOP       = overlay_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
